// File: Bender.yml
package:
  name: exc_ctrl

sources:
  - files:
      - hw/mips_exc_pkg.sv
      - hw/cp0_pkg.sv
      - hw/exception_resolver.sv
      - hw/cp0_regs.sv
      - hw/exc_ctrl_top.sv
  - target: simulation
    files:
      - test/tb_clock_gen.sv
      - test/tb_exc_ctrl.sv

// File: exc_ctrl_top.f
hw/mips_exc_pkg.sv
hw/cp0_pkg.sv
hw/exception_resolver.sv
hw/cp0_regs.sv
hw/exc_ctrl_top.sv
test/tb_clock_gen.sv
test/tb_exc_ctrl.sv

// File: hw/cp0_pkg.sv
package cp0_pkg;

   // mtc0/mfc0 register numbers, select 0 only
   typedef enum logic [4:0] {
      badvaddr = 5'd8,
      count    = 5'd9,
      compare  = 5'd11,
      status   = 5'd12,
      cause    = 5'd13,
      epc      = 5'd14
   } cp0_reg_e;

   // status fields
   localparam int unsigned STATUS_IE    = 0;
   localparam int unsigned STATUS_EXL   = 1;
   localparam int unsigned STATUS_IM_LO = 8;
   localparam int unsigned STATUS_IM_HI = 15;

   // cause fields
   localparam int unsigned CAUSE_EXC_LO = 2;
   localparam int unsigned CAUSE_EXC_HI = 6;
   localparam int unsigned CAUSE_IP_LO  = 8;
   localparam int unsigned CAUSE_IP_HI  = 15;
   localparam int unsigned CAUSE_TI     = 30;
   localparam int unsigned CAUSE_BD     = 31;

   // status after reset, BEV set, IE and EXL clear
   localparam logic [31:0] STATUS_RESET = 32'h0040_0000;

   // software-writable bits
   // status: IM, EXL, IE
   localparam logic [31:0] STATUS_WMASK = 32'h0000_ff03;
   // cause: the two software interrupt bits IP1..IP0
   localparam logic [31:0] CAUSE_WMASK  = 32'h0000_0300;

endpackage

// File: hw/cp0_regs.sv
`timescale 1ns/1ns

module cp0_regs (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     in_delay_slot,
   input  logic                     cp0_we,
   input  logic [5:0]               ext_int,
   input  mips_exc_pkg::exc_type_e  except_type,
   input  logic [31:0]              pc_m,
   input  logic [31:0]              badvaddr,
   input  logic [31:0]              cp0_wdata,
   input  cp0_pkg::cp0_reg_e        cp0_waddr,
   input  cp0_pkg::cp0_reg_e        cp0_raddr,
   output logic [31:0]              cp0_rdata,
   output logic [31:0]              status,
   output logic [31:0]              cause,
   output logic [31:0]              epc
);

   logic [31:0] badvaddr_r;
   logic [31:0] count_r;
   logic [31:0] compare_r;
   // count ticks at half the core clock
   logic        cnt_div;

   logic        exc_commit;
   logic        eret_commit;
   logic        wr_status;
   logic        wr_cause;
   logic        wr_epc;
   logic        wr_count;
   logic        wr_compare;
   logic        ti_nxt;
   logic [31:0] status_nxt;
   logic [31:0] cause_nxt;
   logic [31:0] epc_nxt;
   logic [31:0] badvaddr_nxt;
   logic [31:0] count_nxt;
   logic [31:0] compare_nxt;

   // eret and idle are markers, everything else commits
   assign exc_commit  = (except_type != mips_exc_pkg::no_exc) &&
                        (except_type != mips_exc_pkg::eret);
   assign eret_commit = (except_type == mips_exc_pkg::eret);

   // mtc0 decode
   assign wr_status  = cp0_we && (cp0_waddr == cp0_pkg::status);
   assign wr_cause   = cp0_we && (cp0_waddr == cp0_pkg::cause);
   assign wr_epc     = cp0_we && (cp0_waddr == cp0_pkg::epc);
   assign wr_count   = cp0_we && (cp0_waddr == cp0_pkg::count);
   assign wr_compare = cp0_we && (cp0_waddr == cp0_pkg::compare);

   // timer flag, compare write clears, match sets, else hold
   always_comb begin
      if (wr_compare) begin
         ti_nxt = 1'b0;
      end else if (count_r == compare_r) begin
         ti_nxt = 1'b1;
      end else begin
         ti_nxt = cause[cp0_pkg::CAUSE_TI];
      end
   end

   // next state, mtc0 first and the exception on top of it
   always_comb begin
      status_nxt = status;
      if (wr_status) begin
         status_nxt = (status & ~cp0_pkg::STATUS_WMASK) | (cp0_wdata & cp0_pkg::STATUS_WMASK);
      end
      if (exc_commit) begin
         status_nxt[cp0_pkg::STATUS_EXL] = 1'b1;
      end else if (eret_commit) begin
         status_nxt[cp0_pkg::STATUS_EXL] = 1'b0;
      end

      cause_nxt = cause;
      if (wr_cause) begin
         cause_nxt = (cause & ~cp0_pkg::CAUSE_WMASK) | (cp0_wdata & cp0_pkg::CAUSE_WMASK);
      end
      // hard lines sampled every cycle, timer shares IP7
      cause_nxt[cp0_pkg::CAUSE_IP_HI:cp0_pkg::CAUSE_IP_LO + 2] = {ext_int[5] | ti_nxt,
                                                                   ext_int[4:0]};
      cause_nxt[cp0_pkg::CAUSE_TI] = ti_nxt;
      if (exc_commit) begin
         cause_nxt[cp0_pkg::CAUSE_BD] = in_delay_slot;
         cause_nxt[cp0_pkg::CAUSE_EXC_HI:cp0_pkg::CAUSE_EXC_LO] = except_type;
      end

      epc_nxt = wr_epc ? cp0_wdata : epc;
      if (exc_commit) begin
         // restart at the branch when the fault sits in its slot
         epc_nxt = in_delay_slot ? (pc_m - 32'd4) : pc_m;
      end

      // only address errors touch BadVAddr
      badvaddr_nxt = badvaddr_r;
      if (except_type == mips_exc_pkg::adel || except_type == mips_exc_pkg::ades) begin
         badvaddr_nxt = badvaddr;
      end

      count_nxt   = wr_count ? cp0_wdata : (count_r + {31'd0, cnt_div});
      compare_nxt = wr_compare ? cp0_wdata : compare_r;
   end

   // control and timer state
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         status    <= cp0_pkg::STATUS_RESET;
         cause     <= 32'd0;
         count_r   <= 32'd0;
         compare_r <= 32'd0;
         cnt_div   <= 1'b0;
      end else begin
         status    <= status_nxt;
         cause     <= cause_nxt;
         count_r   <= count_nxt;
         compare_r <= compare_nxt;
         cnt_div   <= ~cnt_div;
      end
   end

   // address payloads
   always_ff @(posedge clk) begin
      epc        <= epc_nxt;
      badvaddr_r <= badvaddr_nxt;
   end

   // mfc0, combinational
   always_comb begin
      case (cp0_raddr)
         cp0_pkg::badvaddr: cp0_rdata = badvaddr_r;
         cp0_pkg::count:    cp0_rdata = count_r;
         cp0_pkg::compare:  cp0_rdata = compare_r;
         cp0_pkg::status:   cp0_rdata = status;
         cp0_pkg::cause:    cp0_rdata = cause;
         cp0_pkg::epc:      cp0_rdata = epc;
         default:           cp0_rdata = 32'd0;
      endcase
   end

   // handler entry always raises EXL
   a_exl_after_exc: assert property (@(posedge clk) disable iff (!rst_n)
      exc_commit |=> status[cp0_pkg::STATUS_EXL])
      else $error("EXL not set after committed exception");

   // compare write acks the timer
   a_ti_clear: assert property (@(posedge clk) disable iff (!rst_n)
      wr_compare |=> !cause[cp0_pkg::CAUSE_TI])
      else $error("timer interrupt still pending after compare write");

endmodule

// File: hw/exc_ctrl_top.sv
`timescale 1ns/1ns

module exc_ctrl_top #(
   parameter logic [31:0] exc_vector = mips_exc_pkg::EXC_VECTOR_DEFAULT
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     ri,
   input  logic                     brk,
   input  logic                     syscall,
   input  logic                     overflow,
   input  logic                     addr_err_sw,
   input  logic                     addr_err_lw,
   input  logic                     pc_err,
   input  logic                     eret_m,
   input  logic [5:0]               ext_int,
   input  logic                     in_delay_slot,
   input  logic [31:0]              pc_m,
   input  logic [31:0]              alu_out_m,
   input  logic                     cp0_we,
   input  cp0_pkg::cp0_reg_e        cp0_waddr,
   input  logic [31:0]              cp0_wdata,
   input  cp0_pkg::cp0_reg_e        cp0_raddr,
   output mips_exc_pkg::exc_type_e  except_type,
   output logic                     flush_except,
   output logic                     pc_trap,
   output logic [31:0]              pc_except,
   output logic [31:0]              cp0_rdata
);

   // resolver to cp0
   logic [31:0] badvaddr;
   // cp0 state back to resolver
   logic [31:0] status;
   logic [31:0] cause;
   logic [31:0] epc;

   exception_resolver #(
      .exc_vector (exc_vector)
   ) u_resolver (
      .ri           (ri),
      .brk          (brk),
      .syscall      (syscall),
      .overflow     (overflow),
      .addr_err_sw  (addr_err_sw),
      .addr_err_lw  (addr_err_lw),
      .pc_err       (pc_err),
      .eret_m       (eret_m),
      .status       (status),
      .cause        (cause),
      .epc          (epc),
      .pc_m         (pc_m),
      .alu_out_m    (alu_out_m),
      .except_type  (except_type),
      .flush_except (flush_except),
      .pc_trap      (pc_trap),
      .pc_except    (pc_except),
      .badvaddr     (badvaddr)
   );

   // commits one edge after the resolver picks
   cp0_regs u_cp0 (
      .clk           (clk),
      .rst_n         (rst_n),
      .in_delay_slot (in_delay_slot),
      .cp0_we        (cp0_we),
      .ext_int       (ext_int),
      .except_type   (except_type),
      .pc_m          (pc_m),
      .badvaddr      (badvaddr),
      .cp0_wdata     (cp0_wdata),
      .cp0_waddr     (cp0_waddr),
      .cp0_raddr     (cp0_raddr),
      .cp0_rdata     (cp0_rdata),
      .status        (status),
      .cause         (cause),
      .epc           (epc)
   );

endmodule

// File: hw/exception_resolver.sv
`timescale 1ns/1ns

module exception_resolver #(
   parameter logic [31:0] exc_vector = mips_exc_pkg::EXC_VECTOR_DEFAULT
) (
   input  logic                     ri,
   input  logic                     brk,
   input  logic                     syscall,
   input  logic                     overflow,
   input  logic                     addr_err_sw,
   input  logic                     addr_err_lw,
   input  logic                     pc_err,
   input  logic                     eret_m,
   input  logic [31:0]              status,
   input  logic [31:0]              cause,
   input  logic [31:0]              epc,
   input  logic [31:0]              pc_m,
   input  logic [31:0]              alu_out_m,
   output mips_exc_pkg::exc_type_e  except_type,
   output logic                     flush_except,
   output logic                     pc_trap,
   output logic [31:0]              pc_except,
   output logic [31:0]              badvaddr
);

   logic [7:0] int_hits;
   logic       int_pend;

   // masked pending lines, soft IP1..0 and hard IP7..2 together
   assign int_hits = status[cp0_pkg::STATUS_IM_HI:cp0_pkg::STATUS_IM_LO]
                   & cause[cp0_pkg::CAUSE_IP_HI:cp0_pkg::CAUSE_IP_LO];

   // global enable and not already inside a handler
   assign int_pend = status[cp0_pkg::STATUS_IE] & ~status[cp0_pkg::STATUS_EXL] & (|int_hits);

   // fixed priority, interrupt first
   always_comb begin
      if (int_pend) begin
         except_type = mips_exc_pkg::int_exc;
      end else if (addr_err_lw | pc_err) begin
         except_type = mips_exc_pkg::adel;
      end else if (ri) begin
         except_type = mips_exc_pkg::ri;
      end else if (syscall) begin
         except_type = mips_exc_pkg::sys;
      end else if (brk) begin
         except_type = mips_exc_pkg::bp;
      end else if (addr_err_sw) begin
         except_type = mips_exc_pkg::ades;
      end else if (overflow) begin
         except_type = mips_exc_pkg::ov;
      end else if (eret_m) begin
         except_type = mips_exc_pkg::eret;
      end else begin
         except_type = mips_exc_pkg::no_exc;
      end
   end

   // redirect target
   // eret returns to epc, all real exceptions go to the one vector
   always_comb begin
      case (except_type)
         mips_exc_pkg::no_exc: pc_except = mips_exc_pkg::ZERO_WORD;
         mips_exc_pkg::eret:   pc_except = epc;
         default:              pc_except = exc_vector;
      endcase
   end

   // eret flushes too
   assign pc_trap      = (except_type != mips_exc_pkg::no_exc);
   assign flush_except = pc_trap;

   // fetch fault reports the pc, data fault the effective address
   assign badvaddr = pc_err ? pc_m : alu_out_m;

   // a trap is raised exactly when some cause is pending
   a_no_trap_when_idle: assert #0 (pc_trap == (int_pend | ri | brk | syscall | overflow |
                                                addr_err_sw | addr_err_lw | pc_err | eret_m))
      else $error("pc_trap does not match the pending exception causes");

endmodule

// File: hw/mips_exc_pkg.sv
package mips_exc_pkg;

   // selected exception of the memory stage
   // numeric values match Cause.ExcCode
   typedef enum logic [4:0] {
      // interrupt
      int_exc = 5'd0,
      // address error on load or instruction fetch
      adel    = 5'd4,
      // address error on store
      ades    = 5'd5,
      // syscall
      sys     = 5'd8,
      // break
      bp      = 5'd9,
      // reserved instruction
      ri      = 5'd10,
      // arithmetic overflow
      ov      = 5'd12,
      // internal marker, eret in memory stage
      // never lands in ExcCode
      eret    = 5'd14,
      // internal marker, nothing to do
      no_exc  = 5'd31
   } exc_type_e;

   // general exception entry, BEV=1 flavour
   // only one vector kept, top level may override it
   localparam logic [31:0] EXC_VECTOR_DEFAULT = 32'hbfc0_0380;

   // redirect address when nothing traps
   localparam logic [31:0] ZERO_WORD = 32'h0000_0000;

endpackage

// File: test/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
   output logic clk,
   output logic rst_n
);

   // 4 ns period
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // hold reset for 16 rising edges, release away from the edge
   initial begin
      rst_n = 1'b0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

// File: test/tb_exc_ctrl.sv
`timescale 1ns/1ns

module tb_exc_ctrl;

   logic                    clk;
   logic                    rst_n;
   logic                    ri, brk, syscall, overflow;
   logic                    addr_err_sw, addr_err_lw, pc_err, eret_m;
   logic [5:0]              ext_int;
   logic                    in_delay_slot;
   logic [31:0]             pc_m;
   logic [31:0]             alu_out_m;
   logic                    cp0_we;
   cp0_pkg::cp0_reg_e       cp0_waddr;
   logic [31:0]             cp0_wdata;
   cp0_pkg::cp0_reg_e       cp0_raddr;
   mips_exc_pkg::exc_type_e except_type;
   logic                    flush_except;
   logic                    pc_trap;
   logic [31:0]             pc_except;
   logic [31:0]             cp0_rdata;

   // reference copy of the cp0 state
   logic [31:0] m_status, m_cause, m_epc, m_badvaddr, m_count, m_compare;
   logic        m_div, m_epc_ok, m_bva_ok;
   int unsigned timer_cycles;
   logic        timer_armed;
   logic [31:0] lfsr;

   mips_exc_pkg::exc_type_e exp_type;
   logic        int_pend, exc_taken, ti_next, int_edge, rd_ok, ti_seen;
   logic [31:0] exp_pc, exp_rdata;

   cp0_pkg::cp0_reg_e rd_sel [0:5] = '{cp0_pkg::badvaddr, cp0_pkg::count, cp0_pkg::compare,
                                       cp0_pkg::status, cp0_pkg::cause, cp0_pkg::epc};

   tb_clock_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

   exc_ctrl_top dut0 (.*);

   // expected response, straight from the priority and redirect rules
   always_comb begin
      int_pend = m_status[0] && !m_status[1] && (|(m_status[15:8] & m_cause[15:8]));
      if (int_pend) exp_type = mips_exc_pkg::int_exc;
      else if (addr_err_lw || pc_err) exp_type = mips_exc_pkg::adel;
      else if (ri) exp_type = mips_exc_pkg::ri;
      else if (syscall) exp_type = mips_exc_pkg::sys;
      else if (brk) exp_type = mips_exc_pkg::bp;
      else if (addr_err_sw) exp_type = mips_exc_pkg::ades;
      else if (overflow) exp_type = mips_exc_pkg::ov;
      else if (eret_m) exp_type = mips_exc_pkg::eret;
      else exp_type = mips_exc_pkg::no_exc;
      exc_taken = (exp_type != mips_exc_pkg::no_exc) && (exp_type != mips_exc_pkg::eret);
      if (exp_type == mips_exc_pkg::no_exc) exp_pc = mips_exc_pkg::ZERO_WORD;
      else if (exp_type == mips_exc_pkg::eret) exp_pc = m_epc;
      else exp_pc = mips_exc_pkg::EXC_VECTOR_DEFAULT;
      // compare write acks, match latches
      if (cp0_we && cp0_waddr == cp0_pkg::compare) ti_next = 1'b0;
      else if (m_count == m_compare) ti_next = 1'b1;
      else ti_next = m_cause[30];
      case (cp0_raddr)
         cp0_pkg::badvaddr: exp_rdata = m_badvaddr;
         cp0_pkg::count:    exp_rdata = m_count;
         cp0_pkg::compare:  exp_rdata = m_compare;
         cp0_pkg::status:   exp_rdata = m_status;
         cp0_pkg::cause:    exp_rdata = m_cause;
         default:           exp_rdata = m_epc;
      endcase
      // epc and badvaddr hold nothing known until first written
      rd_ok = !((cp0_raddr == cp0_pkg::badvaddr && !m_bva_ok) ||
                (cp0_raddr == cp0_pkg::epc && !m_epc_ok));
      // fresh unmasked hard line while interrupts are open
      int_edge = (|(ext_int & m_status[15:10] & ~m_cause[15:10])) && m_status[0] &&
                 !m_status[1] && (exp_type == mips_exc_pkg::no_exc) &&
                 !(cp0_we && cp0_waddr == cp0_pkg::status);
   end

   assign ti_seen = (cp0_raddr == cp0_pkg::cause) && cp0_rdata[30];

   // next-edge state rules
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         m_status     <= 32'h0040_0000;
         m_cause      <= 32'd0;
         m_count      <= 32'd0;
         m_compare    <= 32'd0;
         m_div        <= 1'b0;
         m_epc_ok     <= 1'b0;
         m_bva_ok     <= 1'b0;
         timer_cycles <= 0;
      end else begin
         if (cp0_we && cp0_waddr == cp0_pkg::status) begin
            m_status[1:0]  <= cp0_wdata[1:0];
            m_status[15:8] <= cp0_wdata[15:8];
         end
         if (exc_taken) m_status[1] <= 1'b1;
         else if (exp_type == mips_exc_pkg::eret) m_status[1] <= 1'b0;
         m_cause[15:10] <= {ext_int[5] | ti_next, ext_int[4:0]};
         m_cause[30]    <= ti_next;
         if (cp0_we && cp0_waddr == cp0_pkg::epc) begin
            m_epc    <= cp0_wdata;
            m_epc_ok <= 1'b1;
         end
         if (exc_taken) begin
            m_cause[31]  <= in_delay_slot;
            m_cause[6:2] <= exp_type;
            m_epc        <= in_delay_slot ? pc_m - 32'd4 : pc_m;
            m_epc_ok     <= 1'b1;
         end
         if (exp_type == mips_exc_pkg::adel || exp_type == mips_exc_pkg::ades) begin
            m_badvaddr <= pc_err ? pc_m : alu_out_m;
            m_bva_ok   <= 1'b1;
         end
         // count ticks on every second edge
         m_div <= ~m_div;
         if (cp0_we && cp0_waddr == cp0_pkg::count) begin
            m_count      <= cp0_wdata;
            timer_cycles <= 0;
         end else begin
            m_count      <= m_count + {31'd0, m_div};
            timer_cycles <= timer_cycles + 1;
         end
         if (cp0_we && cp0_waddr == cp0_pkg::compare) m_compare <= cp0_wdata;
      end
   end

   task automatic flag_error(input string what);
      $display("Error at %0t ns: %s", $time, what);
      $display("Simulation failed");
      $fatal(1, "stopped at first error");
   endtask

   a_type: assert property (@(posedge clk) disable iff (!rst_n) except_type == exp_type)
      else flag_error($sformatf("except_type %0d, expected %0d", except_type, exp_type));
   a_redirect: assert property (@(posedge clk) disable iff (!rst_n) pc_except == exp_pc)
      else flag_error($sformatf("pc_except %h, expected %h", pc_except, exp_pc));
   a_flush: assert property (@(posedge clk) disable iff (!rst_n)
      flush_except == (exp_type != mips_exc_pkg::no_exc) && pc_trap == flush_except)
      else flag_error("flush_except or pc_trap does not match the selected exception");
   a_mfc0: assert property (@(posedge clk) disable iff (!rst_n) rd_ok |-> cp0_rdata == exp_rdata)
      else flag_error($sformatf("mfc0 reg %0d read %h, expected %h",
                                cp0_raddr, cp0_rdata, exp_rdata));
   a_int_latency: assert property (@(posedge clk) disable iff (!rst_n)
      int_edge |=> except_type == mips_exc_pkg::int_exc)
      else flag_error("int_exc missing one cycle after an unmasked ext_int rose");
   a_int_masked: assert property (@(posedge clk) disable iff (!rst_n)
      except_type == mips_exc_pkg::int_exc |-> m_status[0] && !m_status[1])
      else flag_error("int_exc taken with IE clear or EXL set");
   a_ti_early: assert property (@(posedge clk) disable iff (!rst_n)
      timer_armed && $rose(ti_seen) |-> timer_cycles >= 40)
      else flag_error($sformatf("timer interrupt after only %0d cycles", timer_cycles));
   a_ti_ack: assert property (@(posedge clk) disable iff (!rst_n)
      cp0_we && cp0_waddr == cp0_pkg::compare |=> !ti_seen)
      else flag_error("Cause.TI still set after compare write");

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
   endfunction

   // one lfsr step per bit
   task automatic draw_bits(input int n, output logic [31:0] v);
      v = 32'd0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   // strobes are single-cycle, so every cycle starts from idle
   task automatic next_cycle();
      @(posedge clk);
      {ri, brk, syscall, overflow, addr_err_sw, addr_err_lw, pc_err, eret_m} <= 8'd0;
      cp0_we <= 1'b0;
   endtask

   task automatic mtc0(input cp0_pkg::cp0_reg_e a, input logic [31:0] d);
      next_cycle();
      cp0_we    <= 1'b1;
      cp0_waddr <= a;
      cp0_wdata <= d;
   endtask

   task automatic random_cycle();
      logic [31:0] r;
      logic [7:0]  s;
      next_cycle();
      // each strobe set with chance 1/8
      for (int b = 0; b < 8; b++) begin
         draw_bits(3, r);
         s[b] = &r[2:0];
      end
      {ri, brk, syscall, overflow, addr_err_sw, addr_err_lw, pc_err, eret_m} <= s;
      draw_bits(32, r);
      pc_m <= r;
      draw_bits(32, r);
      alu_out_m <= r;
      draw_bits(1, r);
      in_delay_slot <= r[0];
      draw_bits(3, r);
      cp0_raddr <= rd_sel[r % 6];
   endtask

   // kind 0..6 walks pc_err, lw, sw, overflow, syscall, brk, ri
   task automatic directed_fault(input int kind, input logic slot);
      next_cycle();
      {ri, brk, syscall, overflow, addr_err_sw, addr_err_lw, pc_err, eret_m} <= 8'd1 << (kind + 1);
      in_delay_slot <= slot;
      pc_m          <= 32'h8000_2000 + 32'(kind * 16);
      alu_out_m     <= 32'h1000_0001 + 32'(kind);
      next_cycle();
      cp0_raddr <= cp0_pkg::epc;
      next_cycle();
      cp0_raddr <= cp0_pkg::cause;
      next_cycle();
      cp0_raddr <= cp0_pkg::badvaddr;
      next_cycle();
      cp0_raddr <= cp0_pkg::status;
      next_cycle();
      eret_m <= 1'b1;
      next_cycle();
   endtask

   task automatic noisy_interrupts(input int n, input logic allow_eret);
      logic [31:0] r;
      repeat (n) begin
         next_cycle();
         draw_bits(6, r);
         ext_int <= r[5:0];
         draw_bits(3, r);
         eret_m <= allow_eret && (&r[2:0]);
      end
   endtask

   initial begin
      logic ti_up;
      int   waited;
      {ri, brk, syscall, overflow, addr_err_sw, addr_err_lw, pc_err, eret_m} = 8'd0;
      ext_int       = 6'd0;
      in_delay_slot = 1'b0;
      pc_m          = 32'h8000_0000;
      alu_out_m     = 32'd0;
      cp0_we        = 1'b0;
      cp0_waddr     = cp0_pkg::status;
      cp0_wdata     = 32'd0;
      cp0_raddr     = cp0_pkg::status;
      timer_armed   = 1'b0;
      lfsr          = 32'hdb6480bb;
      @(posedge rst_n);
      // known epc before any eret
      mtc0(cp0_pkg::epc, 32'h8000_0100);
      // priority and redirect, IE still clear
      repeat (150) random_cycle();
      // commit and eret, out of and in a delay slot
      for (int k = 0; k < 14; k++) directed_fault(k % 7, k >= 7);
      // park the timer, then open IP2 and IP4 only
      mtc0(cp0_pkg::compare, 32'hffff_ffff);
      mtc0(cp0_pkg::status, 32'h0000_1401);
      noisy_interrupts(60, 1'b1);
      mtc0(cp0_pkg::status, 32'h0000_1400);
      noisy_interrupts(30, 1'b0);
      mtc0(cp0_pkg::status, 32'h0000_1403);
      noisy_interrupts(30, 1'b0);
      // timer on IP7
      next_cycle();
      ext_int     <= 6'd0;
      cp0_raddr   <= cp0_pkg::cause;
      timer_armed <= 1'b1;
      mtc0(cp0_pkg::count, 32'd0);
      mtc0(cp0_pkg::compare, 32'd20);
      mtc0(cp0_pkg::status, 32'h0000_8001);
      ti_up  = 1'b0;
      waited = 0;
      while (!ti_up && waited < 100) begin
         next_cycle();
         @(negedge clk);
         ti_up = cp0_rdata[cp0_pkg::CAUSE_TI];
         waited++;
      end
      if (!ti_up) begin
         $display("timer interrupt never showed up in Cause after Count reached Compare");
         $display("Simulation failed");
         $fatal(1, "timer did not fire");
      end
      repeat (4) next_cycle();
      mtc0(cp0_pkg::compare, 32'hffff_ffff);
      repeat (3) next_cycle();
      $display("Simulation completed successfully");
      $finish;
   end

   // reset plus test length, doubled
   initial begin
      #((16 + 600) * 4 * 2);
      $display("watchdog expired, the test sequence did not finish in time");
      $display("Simulation failed");
      $fatal(1, "watchdog");
   end

endmodule
